/* logic/mem_pkg.sv */
package mem_pkg;

    // data and instruction word width
    localparam int xlen = 32;

    // access size, in bytes 1, 2 and 4
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // kind of access
    typedef enum logic [1:0] {
        op_fetch = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_e;

    // byte sequencer states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_read  = 2'd1,
        st_write = 2'd2
    } seq_state_e;

endpackage

/* logic/mem_req_arbiter.sv */
`timescale 1ns/1ps

module mem_req_arbiter #(
    parameter int addr_w = 10
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_en,
    input  logic [addr_w-1:0]        fetch_pc,
    input  logic                     drop,
    input  logic                     ls_en,
    input  logic                     ls_write,
    input  logic [addr_w-1:0]        ls_addr,
    input  mem_pkg::mem_size_e       ls_size,
    input  logic [mem_pkg::xlen-1:0] ls_wdata,
    input  logic                     seq_idle,
    input  mem_pkg::mem_op_e         acc_busy_op,
    output logic                     issue_valid,
    output mem_pkg::mem_op_e         issue_op,
    output logic [addr_w-1:0]        issue_addr,
    output mem_pkg::mem_size_e       issue_size,
    output logic [mem_pkg::xlen-1:0] issue_wdata,
    output logic                     seq_cancel
);

    import mem_pkg::*;

    // one waiting fetch
    logic              fb_valid;
    logic [addr_w-1:0] fb_pc;

    // one waiting load or store
    logic              lb_valid;
    logic              lb_write;
    logic [addr_w-1:0] lb_addr;
    mem_size_e         lb_size;
    logic [xlen-1:0]   lb_wdata;

    logic fb_live;
    logic lb_live;
    logic take_lb;
    logic take_ls;
    logic take_fb;
    logic take_fe;
    logic taken;

    // a drop kills buffered fetch and load in the same cycle, stores survive
    assign fb_live = fb_valid & ~drop;
    assign lb_live = lb_valid & ~(drop & ~lb_write);

    // load/store before fetch, buffered before new within a class
    assign take_lb = lb_live;
    assign take_ls = ~lb_live & ls_en;
    assign take_fb = ~lb_live & ~ls_en & fb_live;
    assign take_fe = ~lb_live & ~ls_en & ~fb_live & fetch_en;

    assign issue_valid = lb_live | ls_en | fb_live | fetch_en;
    assign taken       = issue_valid & seq_idle;

    always_comb begin
        issue_op    = op_fetch;
        issue_addr  = fetch_pc;
        issue_size  = size_word;
        issue_wdata = '0;
        if (take_lb) begin
            issue_op    = lb_write ? op_store : op_load;
            issue_addr  = lb_addr;
            issue_size  = lb_size;
            issue_wdata = lb_wdata;
        end else if (take_ls) begin
            issue_op    = ls_write ? op_store : op_load;
            issue_addr  = ls_addr;
            issue_size  = ls_size;
            issue_wdata = ls_wdata;
        end else if (take_fb) begin
            issue_addr = fb_pc;
        end
    end

    // stop a fetch or load that is already in the sequencer
    assign seq_cancel = drop & ~seq_idle & (acc_busy_op != op_store);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fb_valid <= 1'b0;
            lb_valid <= 1'b0;
        end else begin
            if ((taken && take_fb) || drop) begin
                fb_valid <= 1'b0;
            end
            if ((taken && take_lb) || (lb_valid && !lb_live)) begin
                lb_valid <= 1'b0;
            end
            // new request that could not go straight through
            if (ls_en && !(taken && take_ls)) begin
                lb_valid <= 1'b1;
            end
            if (fetch_en && !(taken && take_fe)) begin
                fb_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ls_en && !(taken && take_ls)) begin
            lb_write <= ls_write;
            lb_addr  <= ls_addr;
            lb_size  <= ls_size;
            lb_wdata <= ls_wdata;
        end
        if (fetch_en && !(taken && take_fe)) begin
            fb_pc <= fetch_pc;
        end
    end

endmodule

/* logic/mem_byte_sequencer.sv */
`timescale 1ns/1ps

module mem_byte_sequencer #(
    parameter int                addr_w  = 10,
    parameter logic [addr_w-1:0] io_addr = '1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  mem_pkg::mem_op_e         issue_op,
    input  logic [addr_w-1:0]        issue_addr,
    input  mem_pkg::mem_size_e       issue_size,
    input  logic [mem_pkg::xlen-1:0] issue_wdata,
    input  logic                     seq_cancel,
    input  logic                     io_full,
    output logic                     seq_idle,
    output mem_pkg::mem_op_e         acc_busy_op,
    output logic [addr_w-1:0]        ram_addr,
    output logic                     ram_we,
    output logic [7:0]               ram_wdata,
    output logic                     io_valid,
    output logic [7:0]               io_data,
    output logic                     byte_valid,
    output logic [1:0]               byte_idx,
    output logic                     acc_first,
    output logic                     acc_done,
    output mem_pkg::mem_op_e         acc_op
);

    import mem_pkg::*;

    seq_state_e        state;
    mem_op_e           op_q;
    logic [addr_w-1:0] run_addr;
    logic [2:0]        cnt;
    logic [2:0]        cnt_end;
    logic [xlen-1:0]   wdata_q;
    logic              is_io;
    logic              io_lock;
    logic [7:0]        wr_byte;
    logic              wr_send;
    logic              rd_last;
    logic              wr_last;

    function automatic logic [2:0] size_bytes(mem_size_e s);
        case (s)
            size_byte: return 3'd1;
            size_half: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

    // store data goes out lowest byte first
    assign wr_byte = wdata_q[8*cnt[1:0] +: 8];

    // io port needs the lock cycle over and room outside
    assign wr_send = (state == st_write) && (!is_io || (!io_lock && !io_full));

    assign ram_addr  = run_addr;
    assign ram_we    = (state == st_write) && !is_io;
    assign ram_wdata = wr_byte;
    assign io_valid  = (state == st_write) && is_io && !io_lock && !io_full;
    assign io_data   = wr_byte;

    // read tail cycle carries the last byte back from memory
    assign rd_last = (state == st_read) && (cnt == cnt_end);
    assign wr_last = (state == st_write) &&
                     (is_io ? (io_lock && cnt == cnt_end) : (cnt == cnt_end - 3'd1));
    assign acc_done = (rd_last | wr_last) & ~seq_cancel;

    assign seq_idle    = (state == st_idle);
    assign acc_busy_op = op_q;
    assign acc_op      = op_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            op_q       <= op_fetch;
            cnt        <= 3'd0;
            io_lock    <= 1'b0;
            byte_valid <= 1'b0;
            acc_first  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            acc_first  <= 1'b0;
            case (state)
                st_idle: begin
                    if (issue_valid) begin
                        acc_first <= 1'b1;
                        op_q      <= issue_op;
                        cnt       <= 3'd0;
                        cnt_end   <= size_bytes(issue_size);
                        run_addr  <= issue_addr;
                        wdata_q   <= issue_wdata;
                        is_io     <= (issue_op == op_store) && (issue_addr == io_addr);
                        io_lock   <= 1'b0;
                        state     <= (issue_op == op_store) ? st_write : st_read;
                    end
                end
                st_read: begin
                    if (seq_cancel || cnt == cnt_end) begin
                        state <= st_idle;
                    end else begin
                        // byte of this address shows up next cycle
                        byte_valid <= 1'b1;
                        byte_idx   <= cnt[1:0];
                        cnt        <= cnt + 3'd1;
                        run_addr   <= run_addr + 1'b1;
                    end
                end
                st_write: begin
                    if (!is_io) begin
                        cnt      <= cnt + 3'd1;
                        run_addr <= run_addr + 1'b1;
                        if (cnt == cnt_end - 3'd1) begin
                            state <= st_idle;
                        end
                    end else if (wr_send) begin
                        io_lock <= 1'b1;
                        cnt     <= cnt + 3'd1;
                    end else if (io_lock) begin
                        io_lock <= 1'b0;
                        if (cnt == cnt_end) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* logic/mem_word_assembler.sv */
`timescale 1ns/1ps

module mem_word_assembler (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     byte_valid,
    input  logic [1:0]               byte_idx,
    input  logic [7:0]               ram_rdata,
    input  logic                     acc_first,
    input  logic                     acc_done,
    input  mem_pkg::mem_op_e         acc_op,
    output logic                     fetch_ok,
    output logic [mem_pkg::xlen-1:0] fetch_inst,
    output logic                     ls_ok,
    output logic [mem_pkg::xlen-1:0] ls_rdata
);

    import mem_pkg::*;

    logic [xlen-1:0] word_q;
    logic [xlen-1:0] word_next;

    // merge the byte arriving this cycle
    always_comb begin
        word_next = word_q;
        if (byte_valid) begin
            word_next[8*byte_idx +: 8] = ram_rdata;
        end
    end

    // lanes never written stay zero
    always_ff @(posedge clk) begin
        if (acc_first) begin
            word_q <= '0;
        end else begin
            word_q <= word_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_ok <= 1'b0;
            ls_ok    <= 1'b0;
        end else begin
            fetch_ok <= acc_done && (acc_op == op_fetch);
            ls_ok    <= acc_done && (acc_op != op_fetch);
        end
    end

    always_ff @(posedge clk) begin
        if (acc_done && acc_op == op_fetch) begin
            fetch_inst <= word_next;
        end
        if (acc_done && acc_op == op_load) begin
            ls_rdata <= word_next;
        end
    end

endmodule

/* logic/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic [addr_w-1:0] ram_addr,
    input  logic              ram_we,
    input  logic [7:0]        ram_wdata,
    output logic [7:0]        ram_rdata
);

    localparam int depth = 2 ** addr_w;

    logic [7:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        ram_rdata <= mem[ram_addr];
    end

endmodule

/* logic/mem_ctrl_top.sv */
`timescale 1ns/1ps

module mem_ctrl_top #(
    parameter int                addr_w  = 10,
    parameter logic [addr_w-1:0] io_addr = '1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_en,
    input  logic [addr_w-1:0]        fetch_pc,
    input  logic                     drop,
    input  logic                     ls_en,
    input  logic                     ls_write,
    input  logic [addr_w-1:0]        ls_addr,
    input  mem_pkg::mem_size_e       ls_size,
    input  logic [mem_pkg::xlen-1:0] ls_wdata,
    input  logic                     io_full,
    output logic                     fetch_ok,
    output logic [mem_pkg::xlen-1:0] fetch_inst,
    output logic                     ls_ok,
    output logic [mem_pkg::xlen-1:0] ls_rdata,
    output logic                     io_valid,
    output logic [7:0]               io_data
);

    import mem_pkg::*;

    // arbiter to sequencer
    logic              issue_valid;
    mem_op_e           issue_op;
    logic [addr_w-1:0] issue_addr;
    mem_size_e         issue_size;
    logic [xlen-1:0]   issue_wdata;
    logic              seq_cancel;
    logic              seq_idle;
    mem_op_e           acc_busy_op;

    // sequencer to memory
    logic [addr_w-1:0] ram_addr;
    logic              ram_we;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    // sequencer to assembler
    logic              byte_valid;
    logic [1:0]        byte_idx;
    logic              acc_first;
    logic              acc_done;
    mem_op_e           acc_op;

    mem_req_arbiter #(
        .addr_w(addr_w)
    ) i_mem_req_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_en   (fetch_en),
        .fetch_pc   (fetch_pc),
        .drop       (drop),
        .ls_en      (ls_en),
        .ls_write   (ls_write),
        .ls_addr    (ls_addr),
        .ls_size    (ls_size),
        .ls_wdata   (ls_wdata),
        .seq_idle   (seq_idle),
        .acc_busy_op(acc_busy_op),
        .issue_valid(issue_valid),
        .issue_op   (issue_op),
        .issue_addr (issue_addr),
        .issue_size (issue_size),
        .issue_wdata(issue_wdata),
        .seq_cancel (seq_cancel)
    );

    mem_byte_sequencer #(
        .addr_w (addr_w),
        .io_addr(io_addr)
    ) i_mem_byte_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_valid(issue_valid),
        .issue_op   (issue_op),
        .issue_addr (issue_addr),
        .issue_size (issue_size),
        .issue_wdata(issue_wdata),
        .seq_cancel (seq_cancel),
        .io_full    (io_full),
        .seq_idle   (seq_idle),
        .acc_busy_op(acc_busy_op),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .io_valid   (io_valid),
        .io_data    (io_data),
        .byte_valid (byte_valid),
        .byte_idx   (byte_idx),
        .acc_first  (acc_first),
        .acc_done   (acc_done),
        .acc_op     (acc_op)
    );

    mem_word_assembler i_mem_word_assembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_valid(byte_valid),
        .byte_idx  (byte_idx),
        .ram_rdata (ram_rdata),
        .acc_first (acc_first),
        .acc_done  (acc_done),
        .acc_op    (acc_op),
        .fetch_ok  (fetch_ok),
        .fetch_inst(fetch_inst),
        .ls_ok     (ls_ok),
        .ls_rdata  (ls_rdata)
    );

    byte_ram #(
        .addr_w(addr_w)
    ) i_byte_ram (
        .clk      (clk),
        .ram_addr (ram_addr),
        .ram_we   (ram_we),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // held for reset_cycles rising edges then let go on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/tb_mem_ctrl.sv */
`timescale 1ns/1ps

module tb_mem_ctrl;

    import mem_pkg::*;

    localparam int                addr_w  = 10;
    localparam logic [addr_w-1:0] io_addr = '1;
    localparam int                ncol    = 7;
    localparam int                max_pat = 64;

    logic              clk;
    logic              rst_n;
    logic              fetch_en;
    logic [addr_w-1:0] fetch_pc;
    logic              drop;
    logic              ls_en;
    logic              ls_write;
    logic [addr_w-1:0] ls_addr;
    mem_size_e         ls_size;
    logic [xlen-1:0]   ls_wdata;
    logic              io_full;
    logic              fetch_ok;
    logic [xlen-1:0]   fetch_inst;
    logic              ls_ok;
    logic [xlen-1:0]   ls_rdata;
    logic              io_valid;
    logic [7:0]        io_data;

    // columns per line: test op addr size wdata expect flags
    logic [31:0]     pat [0:max_pat*ncol-1];
    logic [7:0]      model [0:2**addr_w-1];
    logic [7:0]      io_q [$];
    logic [7:0]      io_exp [$];
    logic [31:0]     rng;
    logic [xlen-1:0] fetch_val;
    logic [xlen-1:0] ls_val;

    int n_pat;
    int errors;
    int test_errs;
    int checks;
    int tests_run;
    int cycle;
    int fetch_seen;
    int ls_seen;
    int fetch_at;
    int ls_at;
    int io_pos;
    int io_errs_base;
    int io_errs = 0;

    clk_gen #(
        .period_ns   (40),
        .reset_cycles(4)
    ) i_clk_gen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    mem_ctrl_top #(
        .addr_w (addr_w),
        .io_addr(io_addr)
    ) i_mem_ctrl_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_en  (fetch_en),
        .fetch_pc  (fetch_pc),
        .drop      (drop),
        .ls_en     (ls_en),
        .ls_write  (ls_write),
        .ls_addr   (ls_addr),
        .ls_size   (ls_size),
        .ls_wdata  (ls_wdata),
        .io_full   (io_full),
        .fetch_ok  (fetch_ok),
        .fetch_inst(fetch_inst),
        .ls_ok     (ls_ok),
        .ls_rdata  (ls_rdata),
        .io_valid  (io_valid),
        .io_data   (io_data)
    );

    // every byte the port takes, in order
    always @(posedge clk) begin
        if (rst_n && io_valid) begin
            if (io_full) begin
                $display("ERROR at %0d ns: io_valid high while io_full is high", $time);
                io_errs++;
            end
            io_q.push_back(io_data);
        end
    end

    function automatic logic [31:0] field(int idx, int col);
        return pat[idx*ncol + col];
    endfunction

    function automatic int access_len(logic [31:0] size);
        case (size)
            32'd0:   return 1;
            32'd1:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // little endian, zero above the access size
    function automatic logic [xlen-1:0] model_word(logic [31:0] addr, logic [31:0] size);
        logic [xlen-1:0]   w;
        logic [addr_w-1:0] a;
        w = '0;
        for (int b = 0; b < access_len(size); b++) begin
            a = addr[addr_w-1:0] + b[addr_w-1:0];
            w[8*b +: 8] = model[a];
        end
        return w;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        errors++;
        test_errs++;
    endtask

    task automatic report_problem(string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    // one falling edge, ok pulses sampled before new inputs go out
    task automatic step();
        @(negedge clk);
        cycle++;
        if (fetch_ok) begin
            fetch_seen++;
            fetch_val = fetch_inst;
            fetch_at  = cycle;
        end
        if (ls_ok) begin
            ls_seen++;
            ls_val = ls_rdata;
            ls_at  = cycle;
        end
        rng     = xorshift(rng);
        io_full = rng[0] & rng[1];
    endtask

    task automatic reset_counts();
        fetch_seen = 0;
        ls_seen    = 0;
        fetch_at   = 0;
        ls_at      = 0;
    endtask

    task automatic clear_req();
        fetch_en = 1'b0;
        ls_en    = 1'b0;
        drop     = 1'b0;
    endtask

    task automatic drive_req(int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] size;
        logic [31:0] wdata;
        op    = field(idx, 1);
        addr  = field(idx, 2);
        size  = field(idx, 3);
        wdata = field(idx, 4);
        if (op == 0) begin
            fetch_en = 1'b1;
            fetch_pc = addr[addr_w-1:0];
        end else begin
            ls_en    = 1'b1;
            ls_write = (op == 2);
            ls_addr  = addr[addr_w-1:0];
            ls_size  = mem_size_e'(size[1:0]);
            ls_wdata = wdata;
        end
        if (op == 2) begin
            for (int b = 0; b < access_len(size); b++) begin
                // io store bypasses memory
                if (addr[addr_w-1:0] == io_addr) begin
                    io_exp.push_back(wdata[8*b +: 8]);
                end else begin
                    model[addr[addr_w-1:0] + b[addr_w-1:0]] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    task automatic wait_done(int want_f, int want_l);
        int start;
        start = cycle;
        while ((fetch_seen < want_f || ls_seen < want_l) && cycle - start < 60) begin
            step();
        end
        if (fetch_seen < want_f || ls_seen < want_l) begin
            report_problem("timed out waiting for an ok pulse");
        end
    endtask

    task automatic check_read(int idx, logic [xlen-1:0] got);
        logic [xlen-1:0] exp;
        logic [31:0]     size;
        size = (field(idx, 1) == 0) ? 32'd2 : field(idx, 3);
        exp  = model_word(field(idx, 2), size);
        checks++;
        if (exp !== field(idx, 5)) begin
            report_mismatch("pattern expect", exp, field(idx, 5));
        end
        if (field(idx, 1) == 0 && got !== exp) begin
            report_mismatch("fetch_inst", exp, got);
        end
        if (field(idx, 1) == 1 && got !== exp) begin
            report_mismatch("ls_rdata", exp, got);
        end
    endtask

    task automatic check_line(int idx);
        if (field(idx, 1) == 0) begin
            check_read(idx, fetch_val);
        end else if (field(idx, 1) == 1) begin
            check_read(idx, ls_val);
        end
    endtask

    task automatic check_io();
        int n_new;
        n_new = io_q.size() - io_pos;
        checks++;
        if (n_new != io_exp.size()) begin
            report_problem($sformatf("%0d IO bytes seen, %0d expected", n_new, io_exp.size()));
        end else begin
            for (int k = 0; k < n_new; k++) begin
                if (io_q[io_pos + k] !== io_exp[k]) begin
                    report_mismatch("io_data", {24'h0, io_exp[k]}, {24'h0, io_q[io_pos + k]});
                end
            end
        end
        io_pos = io_q.size();
        io_exp.delete();
    endtask

    task automatic run_single(int idx);
        logic [31:0] op;
        logic [31:0] flags;
        int          t0;
        int          lat;
        int          want_lat;
        int          want_f;
        op     = field(idx, 1);
        flags  = field(idx, 6);
        want_f = (op == 0) ? 1 : 0;
        drive_req(idx);
        t0 = cycle;
        step();
        clear_req();
        wait_done(want_f, 1 - want_f);
        lat = (op == 0) ? fetch_at - t0 : ls_at - t0;
        repeat (2) step();
        checks++;
        if (fetch_seen != want_f || ls_seen != 1 - want_f) begin
            report_problem("wrong number of ok pulses");
        end
        // read of N bytes takes N+2, memory store N+1
        if (op == 2) begin
            want_lat = access_len(field(idx, 3)) + 1;
        end else if (op == 1) begin
            want_lat = access_len(field(idx, 3)) + 2;
        end else begin
            want_lat = 6;
        end
        if (flags[2] && lat != want_lat) begin
            report_mismatch("ok latency", want_lat, lat);
        end
        check_line(idx);
        check_io();
    endtask

    // line idx is the fetch, idx+1 the load or store in the same cycle
    task automatic run_pair(int idx);
        drive_req(idx);
        drive_req(idx + 1);
        step();
        clear_req();
        wait_done(1, 1);
        repeat (2) step();
        checks++;
        if (fetch_seen != 1 || ls_seen != 1) begin
            report_problem("wrong number of ok pulses");
        end
        if (ls_at >= fetch_at) begin
            report_problem("ls_ok did not come before fetch_ok");
        end
        check_line(idx);
        check_line(idx + 1);
        check_io();
    endtask

    // fetch running, load or store buffered behind it, then a drop
    task automatic run_drop(int idx);
        int want_l;
        want_l = (field(idx + 1, 1) == 2) ? 1 : 0;
        drive_req(idx);
        step();
        clear_req();
        drive_req(idx + 1);
        step();
        clear_req();
        drop = 1'b1;
        step();
        drop = 1'b0;
        if (want_l == 1) begin
            wait_done(0, 1);
            repeat (2) step();
        end else begin
            repeat (20) step();
        end
        checks++;
        if (fetch_seen != 0) begin
            report_problem("fetch_ok seen for a dropped fetch");
        end
        if (want_l == 0 && ls_seen != 0) begin
            report_problem("ls_ok seen for a dropped load");
        end
        if (want_l == 1 && ls_seen != 1) begin
            report_problem("buffered store did not give one ls_ok");
        end
        check_io();
    endtask

    task automatic end_test(logic [31:0] test_no);
        int new_io;
        new_io       = io_errs - io_errs_base;
        io_errs_base = io_errs;
        test_errs    = test_errs + new_io;
        errors       = errors + new_io;
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d: done, no errors", test_no);
        end else begin
            $display("test %0d: done, %0d errors", test_no, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int          idx;
        logic [31:0] cur_test;
        logic [31:0] flags;
        fetch_en     = 1'b0;
        fetch_pc     = '0;
        drop         = 1'b0;
        ls_en        = 1'b0;
        ls_write     = 1'b0;
        ls_addr      = '0;
        ls_size      = size_byte;
        ls_wdata     = '0;
        io_full      = 1'b0;
        rng          = 32'h2ac0;
        errors       = 0;
        test_errs    = 0;
        checks       = 0;
        tests_run    = 0;
        cycle        = 0;
        io_pos       = 0;
        io_errs_base = 0;
        reset_counts();
        for (int k = 0; k < max_pat*ncol; k++) begin
            pat[k] = '0;
        end
        $readmemh("dv/mem_patterns.hex", pat);
        n_pat = 0;
        while (n_pat < max_pat && field(n_pat, 0) != 0) begin
            n_pat++;
        end
        repeat (6) step();
        if (n_pat == 0) begin
            report_problem("no patterns read from dv/mem_patterns.hex");
        end
        idx      = 0;
        cur_test = field(0, 0);
        while (idx < n_pat) begin
            if (field(idx, 0) != cur_test) begin
                end_test(cur_test);
                cur_test = field(idx, 0);
            end
            reset_counts();
            flags = field(idx, 6);
            if (flags[0]) begin
                run_pair(idx);
                idx += 2;
            end else if (flags[1]) begin
                run_drop(idx);
                idx += 2;
            end else begin
                run_single(idx);
                idx += 1;
            end
        end
        end_test(cur_test);
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // budget of 60 cycles per pattern line
    initial begin
        wait (n_pat > 0);
        #(n_pat * 60 * 40);
        $display("watchdog: run did not finish within %0d cycles", n_pat * 60);
        $display("tests failed");
        $finish;
    end

endmodule

/* dv/mem_patterns.hex */
// test op addr size wdata expect flags
// op 0 fetch 1 load 2 store; size 0 byte 1 half 2 word; flags 1 paired 2 drop 4 timed
1 2 010 2 a1b2c3d4 00000000 0
1 0 010 2 00000000 a1b2c3d4 0
1 1 011 0 00000000 000000c3 0
1 1 012 1 00000000 0000a1b2 0
1 1 010 2 00000000 a1b2c3d4 0
1 2 020 2 11223344 00000000 0
1 2 021 1 0000beef 00000000 0
1 1 020 2 00000000 11beef44 0
1 1 023 0 00000000 00000011 0
1 1 021 1 00000000 0000beef 0
2 0 010 2 00000000 a1b2c3d4 1
2 1 020 2 00000000 11beef44 0
2 0 030 2 00000000 55667788 1
2 2 030 2 55667788 00000000 0
3 1 010 2 00000000 a1b2c3d4 4
3 2 040 2 cafef00d 00000000 4
3 1 041 1 00000000 0000fef0 4
3 1 043 0 00000000 000000ca 4
3 2 044 0 00000077 00000000 4
4 0 010 2 00000000 a1b2c3d4 2
4 1 020 2 00000000 11beef44 0
4 0 010 2 00000000 a1b2c3d4 2
4 2 050 2 0badc0de 00000000 0
4 1 050 2 00000000 0badc0de 0
5 2 3fc 2 9abcdef0 00000000 0
5 2 3ff 2 12345678 00000000 0
5 2 3ff 1 0000a55a 00000000 0
5 1 3fc 2 00000000 9abcdef0 0
5 0 3fc 2 00000000 9abcdef0 0

/* build.f */
logic/mem_pkg.sv
logic/mem_req_arbiter.sv
logic/mem_byte_sequencer.sv
logic/mem_word_assembler.sv
logic/byte_ram.sv
logic/mem_ctrl_top.sv
dv/clk_gen.sv
dv/tb_mem_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_mem_ctrl
FILELIST  ?= build.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
